// File: logic/rv32i_pkg.sv
package rv32i_pkg;

	// ----------------------------------------
	// widths and fixed constants
	// ----------------------------------------
	localparam int unsigned xlen = 32;
	localparam int unsigned reg_count = 32;
	localparam logic [6:0] funct7_alt = 7'b0100000;
	localparam int unsigned pc_step = 4;

	typedef logic [xlen-1:0] rv32i_word;
	typedef logic [$clog2(reg_count)-1:0] rv32i_reg;

	// ----------------------------------------
	// instruction encodings
	// ----------------------------------------
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		lb  = 3'b000,
		lh  = 3'b001,
		lw  = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} load_funct3_t;

	typedef enum logic [2:0] {
		sb = 3'b000,
		sh = 3'b001,
		sw = 3'b010
	} store_funct3_t;

	// sr covers srl and sra, split by funct7
	typedef enum logic [2:0] {
		add  = 3'b000,
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101,
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	// ----------------------------------------
	// datapath selects
	// ----------------------------------------
	typedef enum logic {
		alumux1_rs1 = 1'b0,
		alumux1_pc  = 1'b1
	} alumux1_sel_t;

	typedef enum logic [2:0] {
		alumux2_i_imm = 3'd0,
		alumux2_u_imm = 3'd1,
		alumux2_b_imm = 3'd2,
		alumux2_s_imm = 3'd3,
		alumux2_j_imm = 3'd4,
		alumux2_rs2   = 3'd5
	} alumux2_sel_t;

	typedef enum logic {
		cmpmux_rs2   = 1'b0,
		cmpmux_i_imm = 1'b1
	} cmpmux_sel_t;

	typedef enum logic [1:0] {
		regfilemux_alu      = 2'd0,
		regfilemux_br_en    = 2'd1,
		regfilemux_u_imm    = 2'd2,
		regfilemux_pc_plus4 = 2'd3
	} regfilemux_sel_t;

	// ----------------------------------------
	// control word and stage packets
	// ----------------------------------------
	typedef struct packed {
		rv32i_opcode     opcode;
		logic [2:0]      funct3;
		logic [6:0]      funct7;
		rv32i_word       i_imm;
		rv32i_word       s_imm;
		rv32i_word       b_imm;
		rv32i_word       u_imm;
		rv32i_word       j_imm;
		rv32i_reg        src1;
		rv32i_reg        src2;
		rv32i_reg        dest;
		alu_ops          aluop;
		branch_funct3_t  cmpop;
		alumux1_sel_t    alumux1_sel;
		alumux2_sel_t    alumux2_sel;
		cmpmux_sel_t     cmpmux_sel;
		regfilemux_sel_t regfilemux_sel;
		logic            load_regfile;
		logic            mem_read;
		logic            mem_write;
		logic [3:0]      wmask;
		logic            rs1_valid;
		logic            rs2_valid;
		logic            rd_valid;
	} control_word_t;

	typedef struct packed {
		logic          valid;
		rv32i_word     pc;
		control_word_t cw;
		rv32i_word     rs1_data;
		rv32i_word     rs2_data;
	} issue_pkt_t;

	typedef struct packed {
		logic      valid;
		rv32i_reg  rd;
		rv32i_word data;
	} wb_pkt_t;

	typedef struct packed {
		logic       read;
		logic       write;
		rv32i_word  addr;
		rv32i_word  wdata;
		logic [3:0] wmask;
	} mem_req_t;

	typedef struct packed {
		logic      valid;
		logic      taken;
		rv32i_word target;
	} branch_t;

endpackage

// File: logic/rv32i_decode.sv
`timescale 1ns/1ps

module rv32i_decode (
	input  rv32i_pkg::rv32i_word     i_instr,
	output rv32i_pkg::control_word_t o_cw
);
	import rv32i_pkg::*;

	function automatic control_word_t set_rd(control_word_t c, regfilemux_sel_t sel);
		control_word_t r;
		r = c;
		r.load_regfile = 1'b1;
		r.rd_valid = 1'b1;
		r.regfilemux_sel = sel;
		return r;
	endfunction

	function automatic control_word_t set_alu(control_word_t c, alumux1_sel_t sel1,
			alumux2_sel_t sel2, alu_ops op);
		control_word_t r;
		r = c;
		r.alumux1_sel = sel1;
		r.alumux2_sel = sel2;
		r.aluop = op;
		return r;
	endfunction

	function automatic control_word_t set_cmp(control_word_t c, cmpmux_sel_t sel,
			branch_funct3_t op);
		control_word_t r;
		r = c;
		r.cmpmux_sel = sel;
		r.cmpop = op;
		return r;
	endfunction

	// shared by op_imm and op_reg, only the second operand differs
	function automatic control_word_t set_arith(control_word_t c, alumux2_sel_t src2,
			cmpmux_sel_t csel, logic use_sub);
		control_word_t r;
		logic          alt;
		r = set_rd(c, regfilemux_alu);
		alt = (c.funct7 == funct7_alt);
		unique case (arith_funct3_t'(c.funct3))
			add:  r = set_alu(r, alumux1_rs1, src2, use_sub ? alu_sub : alu_add);
			sll:  r = set_alu(r, alumux1_rs1, src2, alu_sll);
			slt: begin
				r = set_cmp(r, csel, blt);
				r.regfilemux_sel = regfilemux_br_en;
			end
			sltu: begin
				r = set_cmp(r, csel, bltu);
				r.regfilemux_sel = regfilemux_br_en;
			end
			axor: r = set_alu(r, alumux1_rs1, src2, alu_xor);
			sr:   r = set_alu(r, alumux1_rs1, src2, alt ? alu_sra : alu_srl);
			aor:  r = set_alu(r, alumux1_rs1, src2, alu_or);
			aand: r = set_alu(r, alumux1_rs1, src2, alu_and);
		endcase
		return r;
	endfunction

	always_comb begin : decode_actions
		o_cw.opcode = rv32i_opcode'(i_instr[6:0]);
		o_cw.funct3 = i_instr[14:12];
		o_cw.funct7 = i_instr[31:25];

		o_cw.i_imm = {{21{i_instr[31]}}, i_instr[30:20]};
		o_cw.s_imm = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
		o_cw.b_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
		o_cw.u_imm = {i_instr[31:12], 12'h000};
		o_cw.j_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

		o_cw.src1 = i_instr[19:15];
		o_cw.src2 = i_instr[24:20];
		o_cw.dest = i_instr[11:7];

		// idle control: nothing written, nothing requested
		o_cw.aluop = alu_add;
		o_cw.cmpop = beq;
		o_cw.alumux1_sel = alumux1_rs1;
		o_cw.alumux2_sel = alumux2_i_imm;
		o_cw.cmpmux_sel = cmpmux_rs2;
		o_cw.regfilemux_sel = regfilemux_alu;
		o_cw.load_regfile = 1'b0;
		o_cw.mem_read = 1'b0;
		o_cw.mem_write = 1'b0;
		o_cw.wmask = 4'b0000;
		o_cw.rs1_valid = 1'b0;
		o_cw.rs2_valid = 1'b0;
		o_cw.rd_valid = 1'b0;

		unique case (o_cw.opcode)
			op_lui: o_cw = set_rd(o_cw, regfilemux_u_imm);
			op_auipc: begin
				o_cw = set_alu(o_cw, alumux1_pc, alumux2_u_imm, alu_add);
				o_cw = set_rd(o_cw, regfilemux_alu);
			end
			op_jal: begin
				o_cw = set_alu(o_cw, alumux1_pc, alumux2_j_imm, alu_add);
				o_cw = set_rd(o_cw, regfilemux_pc_plus4);
			end
			op_jalr: begin
				o_cw = set_alu(o_cw, alumux1_rs1, alumux2_i_imm, alu_add);
				o_cw = set_rd(o_cw, regfilemux_pc_plus4);
				o_cw.rs1_valid = 1'b1;
			end
			op_br: begin
				o_cw = set_alu(o_cw, alumux1_pc, alumux2_b_imm, alu_add);
				o_cw = set_cmp(o_cw, cmpmux_rs2, branch_funct3_t'(o_cw.funct3));
				o_cw.rs1_valid = 1'b1;
				o_cw.rs2_valid = 1'b1;
			end
			op_load: begin
				// no data memory here, so rd is named but never loaded
				o_cw = set_alu(o_cw, alumux1_rs1, alumux2_i_imm, alu_add);
				o_cw.rs1_valid = 1'b1;
				o_cw.rd_valid = 1'b1;
				unique case (load_funct3_t'(o_cw.funct3))
					lb, lh, lw, lbu, lhu: o_cw.mem_read = 1'b1;
					default: ;
				endcase
			end
			op_store: begin
				o_cw = set_alu(o_cw, alumux1_rs1, alumux2_s_imm, alu_add);
				o_cw.rs1_valid = 1'b1;
				o_cw.rs2_valid = 1'b1;
				o_cw.mem_write = 1'b1;
				unique case (store_funct3_t'(o_cw.funct3))
					sb: o_cw.wmask = 4'b0001;
					sh: o_cw.wmask = 4'b0011;
					sw: o_cw.wmask = 4'b1111;
					default: o_cw.mem_write = 1'b0;
				endcase
			end
			op_imm: begin
				o_cw = set_arith(o_cw, alumux2_i_imm, cmpmux_i_imm, 1'b0);
				o_cw.rs1_valid = 1'b1;
			end
			op_reg: begin
				o_cw = set_arith(o_cw, alumux2_rs2, cmpmux_rs2, o_cw.funct7 == funct7_alt);
				o_cw.rs1_valid = 1'b1;
				o_cw.rs2_valid = 1'b1;
			end
			default: ;
		endcase

		// x0 stays zero
		if (o_cw.dest == '0) begin
			o_cw.rd_valid = 1'b0;
			o_cw.load_regfile = 1'b0;
		end
	end

endmodule

// File: logic/rv32i_regfile.sv
`timescale 1ns/1ps

module rv32i_regfile (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  rv32i_pkg::rv32i_reg  i_rs1,
	input  rv32i_pkg::rv32i_reg  i_rs2,
	output rv32i_pkg::rv32i_word o_rs1_data,
	output rv32i_pkg::rv32i_word o_rs2_data,
	input  rv32i_pkg::wb_pkt_t   i_wb
);
	import rv32i_pkg::*;

	rv32i_word regs [reg_count];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.valid) begin
			regs[i_wb.rd] <= i_wb.data;
		end
	end

	// reads see the old value during a write cycle
	assign o_rs1_data = regs[i_rs1];
	assign o_rs2_data = regs[i_rs2];

endmodule

// File: logic/rv32i_issue.sv
`timescale 1ns/1ps

module rv32i_issue (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_instr_valid,
	input  rv32i_pkg::rv32i_word     i_pc,
	input  rv32i_pkg::control_word_t i_cw,
	output rv32i_pkg::rv32i_reg      o_rs1,
	output rv32i_pkg::rv32i_reg      o_rs2,
	input  rv32i_pkg::rv32i_word     i_rs1_data,
	input  rv32i_pkg::rv32i_word     i_rs2_data,
	input  rv32i_pkg::wb_pkt_t       i_fwd,
	output rv32i_pkg::issue_pkt_t    o_pkt
);
	import rv32i_pkg::*;

	logic      fwd_rs1;
	logic      fwd_rs2;
	rv32i_word rs1_val;
	rv32i_word rs2_val;

	assign o_rs1 = i_cw.src1;
	assign o_rs2 = i_cw.src2;

	// ----------------------------------------
	// operand bypass from execute
	// ----------------------------------------
	// the regfile write of the execute result lands at the same edge,
	// so a dependent instruction one behind must take it from here
	assign fwd_rs1 = i_cw.rs1_valid && i_fwd.valid && (i_fwd.rd == i_cw.src1);
	assign fwd_rs2 = i_cw.rs2_valid && i_fwd.valid && (i_fwd.rd == i_cw.src2);

	assign rs1_val = fwd_rs1 ? i_fwd.data : i_rs1_data;
	assign rs2_val = fwd_rs2 ? i_fwd.data : i_rs2_data;

	// ----------------------------------------
	// issue to execute register
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_pkt.valid <= 1'b0;
		end else begin
			o_pkt.valid <= i_instr_valid;
			if (i_instr_valid) begin
				o_pkt.pc <= i_pc;
				o_pkt.cw <= i_cw;
				o_pkt.rs1_data <= rs1_val;
				o_pkt.rs2_data <= rs2_val;
			end
		end
	end

endmodule

// File: logic/rv32i_execute.sv
`timescale 1ns/1ps

module rv32i_execute (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  rv32i_pkg::issue_pkt_t i_pkt,
	output rv32i_pkg::wb_pkt_t    o_wb_next,
	output rv32i_pkg::wb_pkt_t    o_wb,
	output rv32i_pkg::mem_req_t   o_mem,
	output rv32i_pkg::branch_t    o_branch
);
	import rv32i_pkg::*;

	control_word_t cw;
	rv32i_word     alu_a;
	rv32i_word     alu_b;
	rv32i_word     cmp_b;
	rv32i_word     alu_out;
	rv32i_word     pc_plus4;
	rv32i_word     wb_data;
	logic          br_en;
	logic          is_branch;
	logic          is_jump;
	mem_req_t      mem_next;
	branch_t       branch_next;

	assign cw = i_pkt.cw;
	assign pc_plus4 = i_pkt.pc + rv32i_word'(pc_step);

	// ----------------------------------------
	// operand muxes
	// ----------------------------------------
	assign alu_a = (cw.alumux1_sel == alumux1_pc) ? i_pkt.pc : i_pkt.rs1_data;
	assign cmp_b = (cw.cmpmux_sel == cmpmux_i_imm) ? cw.i_imm : i_pkt.rs2_data;

	always_comb begin
		case (cw.alumux2_sel)
			alumux2_u_imm: alu_b = cw.u_imm;
			alumux2_b_imm: alu_b = cw.b_imm;
			alumux2_s_imm: alu_b = cw.s_imm;
			alumux2_j_imm: alu_b = cw.j_imm;
			alumux2_rs2:   alu_b = i_pkt.rs2_data;
			default:       alu_b = cw.i_imm;
		endcase
	end

	// ----------------------------------------
	// alu and comparator
	// ----------------------------------------
	always_comb begin
		unique case (cw.aluop)
			alu_add: alu_out = alu_a + alu_b;
			alu_sll: alu_out = alu_a << alu_b[4:0];
			alu_sra: alu_out = rv32i_word'($signed(alu_a) >>> alu_b[4:0]);
			alu_sub: alu_out = alu_a - alu_b;
			alu_xor: alu_out = alu_a ^ alu_b;
			alu_srl: alu_out = alu_a >> alu_b[4:0];
			alu_or:  alu_out = alu_a | alu_b;
			alu_and: alu_out = alu_a & alu_b;
		endcase
	end

	always_comb begin
		case (cw.cmpop)
			beq:     br_en = (i_pkt.rs1_data == cmp_b);
			bne:     br_en = (i_pkt.rs1_data != cmp_b);
			blt:     br_en = ($signed(i_pkt.rs1_data) < $signed(cmp_b));
			bge:     br_en = ($signed(i_pkt.rs1_data) >= $signed(cmp_b));
			bltu:    br_en = (i_pkt.rs1_data < cmp_b);
			bgeu:    br_en = (i_pkt.rs1_data >= cmp_b);
			default: br_en = 1'b0;
		endcase
	end

	// ----------------------------------------
	// writeback, memory and branch results
	// ----------------------------------------
	always_comb begin
		unique case (cw.regfilemux_sel)
			regfilemux_alu:      wb_data = alu_out;
			regfilemux_br_en:    wb_data = rv32i_word'(br_en);
			regfilemux_u_imm:    wb_data = cw.u_imm;
			regfilemux_pc_plus4: wb_data = pc_plus4;
		endcase
	end

	// also feeds the regfile write port and the issue bypass
	assign o_wb_next.valid = i_pkt.valid && cw.load_regfile && cw.rd_valid;
	assign o_wb_next.rd = cw.dest;
	assign o_wb_next.data = wb_data;

	assign mem_next.read = i_pkt.valid && cw.mem_read;
	assign mem_next.write = i_pkt.valid && cw.mem_write;
	assign mem_next.addr = alu_out;
	assign mem_next.wdata = i_pkt.rs2_data;
	assign mem_next.wmask = cw.wmask;

	assign is_branch = (cw.opcode == op_br);
	assign is_jump = (cw.opcode == op_jal) || (cw.opcode == op_jalr);

	assign branch_next.valid = i_pkt.valid && (is_branch || is_jump);
	assign branch_next.taken = is_jump || (is_branch && br_en);
	// jalr clears bit 0 of its target
	assign branch_next.target = (cw.opcode == op_jalr) ? {alu_out[31:1], 1'b0} : alu_out;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_wb.valid <= 1'b0;
			o_mem.read <= 1'b0;
			o_mem.write <= 1'b0;
			o_branch.valid <= 1'b0;
		end else begin
			o_wb <= o_wb_next;
			o_mem <= mem_next;
			o_branch <= branch_next;
		end
	end

endmodule

// File: logic/rv32i_core_slice.sv
`timescale 1ns/1ps

module rv32i_core_slice (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_instr_valid,
	input  rv32i_pkg::rv32i_word i_instr,
	input  rv32i_pkg::rv32i_word i_pc,
	output rv32i_pkg::wb_pkt_t   o_wb,
	output rv32i_pkg::mem_req_t  o_mem,
	output rv32i_pkg::branch_t   o_branch
);
	import rv32i_pkg::*;

	control_word_t cw;
	rv32i_reg      rs1;
	rv32i_reg      rs2;
	rv32i_word     rs1_data;
	rv32i_word     rs2_data;
	wb_pkt_t       wb_next;
	issue_pkt_t    ex_pkt;

	rv32i_decode u_decode (
		.i_instr (i_instr),
		.o_cw    (cw)
	);

	rv32i_regfile u_regfile (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rs1      (rs1),
		.i_rs2      (rs2),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.i_wb       (wb_next)
	);

	rv32i_issue u_issue (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_instr_valid (i_instr_valid),
		.i_pc          (i_pc),
		.i_cw          (cw),
		.o_rs1         (rs1),
		.o_rs2         (rs2),
		.i_rs1_data    (rs1_data),
		.i_rs2_data    (rs2_data),
		.i_fwd         (wb_next),
		.o_pkt         (ex_pkt)
	);

	rv32i_execute u_execute (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_pkt     (ex_pkt),
		.o_wb_next (wb_next),
		.o_wb      (o_wb),
		.o_mem     (o_mem),
		.o_branch  (o_branch)
	);

endmodule

// File: include/tb_rv32i_encode.svh
`ifndef TB_RV32I_ENCODE_SVH
`define TB_RV32I_ENCODE_SVH

// ----------------------------------------
// instruction word builders
// ----------------------------------------
function automatic logic [31:0] encode_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
	return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encode_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encode_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [6:0] op);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

// imm bit 0 is dropped, offsets are even
function automatic logic [31:0] encode_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [6:0] op);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
endfunction

function automatic logic [31:0] encode_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] encode_j(logic [20:0] imm, logic [4:0] rd, logic [6:0] op);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
endfunction

// reference result of an arithmetic funct3, alt picks sub or sra
function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
	case (f3)
		3'b000:  return alt ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return {31'b0, $signed(a) < $signed(b)};
		3'b011:  return {31'b0, a < b};
		3'b100:  return a ^ b;
		3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

`endif

// File: verification/tb_rv32i_core_slice.sv
`timescale 1ns/1ps

module tb_rv32i_core_slice;
	import rv32i_pkg::*;

	`include "tb_rv32i_encode.svh"

	localparam int clk_period = 20;
	localparam int max_cycles = 3000;

	// what the outputs must show two edges after an instruction is driven
	typedef struct packed {
		wb_pkt_t  wb;
		mem_req_t mem;
		branch_t  br;
	} expect_t;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_instr_valid;
	rv32i_word   i_instr;
	rv32i_word   i_pc;
	wb_pkt_t     o_wb;
	mem_req_t    o_mem;
	branch_t     o_branch;

	rv32i_word   shadow [32];
	expect_t     exp_q [$];
	expect_t     chk;
	rv32i_word   cur_pc;
	logic [31:0] word;
	logic [11:0] imm12;
	logic [2:0]  f3v;
	logic [2:0]  br_kinds [6];
	rv32i_reg    ra;
	rv32i_reg    rb;
	rv32i_reg    rc;
	int          seed;
	int          cycles = 0;

	rv32i_core_slice DUT (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_pc          (i_pc),
		.o_wb          (o_wb),
		.o_mem         (o_mem),
		.o_branch      (o_branch)
	);

	initial begin
		i_clk = 1'b0;
	end

	always #(clk_period / 2) i_clk = ~i_clk;

	// ----------------------------------------
	// failure reporting and run limit
	// ----------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want));
	endtask

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			abort_run($sformatf("timeout: run still going after %0d cycles", cycles));
		end
	end

	// ----------------------------------------
	// stimulus and shadow model
	// ----------------------------------------
	function automatic rv32i_word sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	task automatic send(input rv32i_word instr, input expect_t e);
		@(posedge i_clk);
		i_instr_valid <= 1'b1;
		i_instr <= instr;
		i_pc <= cur_pc;
		exp_q.push_back(e);
		cur_pc = cur_pc + 4;
	endtask

	task automatic bubble();
		expect_t e;
		e = '0;
		@(posedge i_clk);
		i_instr_valid <= 1'b0;
		exp_q.push_back(e);
	endtask

	// x0 never shows up on o_wb and never changes
	task automatic put_rd(inout expect_t e, input rv32i_reg rd, input rv32i_word val);
		if (rd != 0) begin
			e.wb.valid = 1'b1;
			e.wb.rd = rd;
			e.wb.data = val;
			shadow[rd] = val;
		end
	endtask

	task automatic r_op(input logic [2:0] f3, input logic alt, input rv32i_reg rd,
			input rv32i_reg rs1, input rv32i_reg rs2);
		expect_t e;
		e = '0;
		put_rd(e, rd, ref_alu(f3, alt, shadow[rs1], shadow[rs2]));
		send(encode_r(alt ? funct7_alt : 7'h00, rs2, rs1, f3, rd, op_reg), e);
	endtask

	task automatic i_op(input logic [2:0] f3, input rv32i_reg rd, input rv32i_reg rs1,
			input logic [11:0] imm);
		expect_t e;
		logic    alt;
		e = '0;
		alt = (f3 == 3'b101) && imm[10];
		put_rd(e, rd, ref_alu(f3, alt, shadow[rs1], sext12(imm)));
		send(encode_i(imm, rs1, f3, rd, op_imm), e);
	endtask

	task automatic u_op(input logic pc_rel, input rv32i_reg rd, input logic [19:0] imm);
		expect_t e;
		e = '0;
		put_rd(e, rd, {imm, 12'h000} + (pc_rel ? cur_pc : 32'h0));
		send(encode_u(imm, rd, pc_rel ? op_auipc : op_lui), e);
	endtask

	task automatic load_const(input rv32i_reg rd, input rv32i_word val);
		u_op(1'b0, rd, val[31:12] + val[11]);
		i_op(3'b000, rd, rd, val[11:0]);
	endtask

	task automatic jump(input logic via_reg, input rv32i_reg rd, input rv32i_reg rs1,
			input logic [20:0] imm);
		expect_t e;
		e = '0;
		e.br.valid = 1'b1;
		e.br.taken = 1'b1;
		if (via_reg) begin
			e.br.target = (shadow[rs1] + sext12(imm[11:0])) & ~32'h1;
		end else begin
			e.br.target = cur_pc + {{11{imm[20]}}, imm};
		end
		put_rd(e, rd, cur_pc + 4);
		if (via_reg) begin
			send(encode_i(imm[11:0], rs1, 3'b000, rd, op_jalr), e);
		end else begin
			send(encode_j(imm, rd, op_jal), e);
		end
	endtask

	task automatic branch(input logic [2:0] f3, input rv32i_reg rs1, input rv32i_reg rs2,
			input logic [12:0] imm);
		expect_t   e;
		rv32i_word a;
		rv32i_word b;
		a = shadow[rs1];
		b = shadow[rs2];
		e = '0;
		e.br.valid = 1'b1;
		e.br.target = cur_pc + {{19{imm[12]}}, imm[12:1], 1'b0};
		case (f3)
			3'b000:  e.br.taken = (a == b);
			3'b001:  e.br.taken = (a != b);
			3'b100:  e.br.taken = ($signed(a) < $signed(b));
			3'b101:  e.br.taken = ($signed(a) >= $signed(b));
			3'b110:  e.br.taken = (a < b);
			default: e.br.taken = (a >= b);
		endcase
		send(encode_b(imm, rs2, rs1, f3, op_br), e);
	endtask

	// loads name rd but leave it alone
	task automatic mem_op(input logic store, input logic [2:0] f3, input rv32i_reg r,
			input rv32i_reg rs1, input logic [11:0] imm);
		expect_t e;
		e = '0;
		e.mem.read = !store;
		e.mem.write = store;
		e.mem.addr = shadow[rs1] + sext12(imm);
		if (store) begin
			e.mem.wdata = shadow[r];
			e.mem.wmask = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
			send(encode_s(imm, r, rs1, f3, op_store), e);
		end else begin
			send(encode_i(imm, rs1, f3, r, op_load), e);
		end
	endtask

	// ----------------------------------------
	// output checks
	// ----------------------------------------
	always @(negedge i_clk) begin
		if (i_rst_n && exp_q.size() > 2) begin
			chk = exp_q.pop_front();
			assert (o_wb.valid == chk.wb.valid)
				else report_mismatch("o_wb.valid", o_wb.valid, chk.wb.valid);
			if (chk.wb.valid) begin
				assert (o_wb.rd == chk.wb.rd)
					else report_mismatch("o_wb.rd", o_wb.rd, chk.wb.rd);
				assert (o_wb.data == chk.wb.data)
					else report_mismatch("o_wb.data", o_wb.data, chk.wb.data);
			end
			assert (o_mem.read == chk.mem.read)
				else report_mismatch("o_mem.read", o_mem.read, chk.mem.read);
			assert (o_mem.write == chk.mem.write)
				else report_mismatch("o_mem.write", o_mem.write, chk.mem.write);
			if (chk.mem.read || chk.mem.write) begin
				assert (o_mem.addr == chk.mem.addr)
					else report_mismatch("o_mem.addr", o_mem.addr, chk.mem.addr);
			end
			if (chk.mem.write) begin
				assert (o_mem.wdata == chk.mem.wdata)
					else report_mismatch("o_mem.wdata", o_mem.wdata, chk.mem.wdata);
				assert (o_mem.wmask == chk.mem.wmask)
					else report_mismatch("o_mem.wmask", o_mem.wmask, chk.mem.wmask);
			end
			assert (o_branch.valid == chk.br.valid)
				else report_mismatch("o_branch.valid", o_branch.valid, chk.br.valid);
			if (chk.br.valid) begin
				assert (o_branch.taken == chk.br.taken)
					else report_mismatch("o_branch.taken", o_branch.taken, chk.br.taken);
				assert (o_branch.target == chk.br.target)
					else report_mismatch("o_branch.target", o_branch.target, chk.br.target);
			end
		end
	end

	initial begin
		seed = 26501;
		cur_pc = 32'h0000_1000;
		br_kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		i_rst_n = 1'b0;
		i_instr_valid = 1'b0;
		i_instr = '0;
		i_pc = '0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		repeat (10) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		assert (!o_wb.valid && !o_mem.read && !o_mem.write && !o_branch.valid)
			else abort_run("an output valid is high right after reset");

		// random operands through lui and addi
		for (int r = 1; r < 16; r++) begin
			load_const(rv32i_reg'(r), $random(seed));
		end
		load_const(5'd12, 32'h0000_0010);
		load_const(5'd15, 32'hffff_fff0);
		i_op(3'b000, 5'd14, 5'd13, 12'h000);

		for (int f = 0; f < 8; f++) begin
			r_op(3'(f), 1'b0, 5'(16 + f), 5'(1 + f), 5'(9 + f));
			imm12 = 12'($random(seed));
			if (f == 1 || f == 5) begin
				imm12[11:5] = 7'h00;
			end
			i_op(3'(f), 5'(17 + f), 5'(2 + f), imm12);
		end
		r_op(3'b000, 1'b1, 5'd24, 5'd3, 5'd4);
		r_op(3'b101, 1'b1, 5'd25, 5'd15, 5'd5);
		i_op(3'b101, 5'd25, 5'd15, {funct7_alt, 5'd7});

		// dependency distances of one and two
		r_op(3'b000, 1'b0, 5'd26, 5'd1, 5'd2);
		r_op(3'b000, 1'b1, 5'd27, 5'd26, 5'd3);
		r_op(3'b100, 1'b0, 5'd28, 5'd4, 5'd26);
		r_op(3'b110, 1'b0, 5'd26, 5'd27, 5'd28);
		i_op(3'b000, 5'd26, 5'd26, 12'h7ff);
		mem_op(1'b1, 3'b010, 5'd26, 5'd27, 12'h010);
		branch(3'b000, 5'd26, 5'd26, 13'h0040);
		for (int n = 0; n < 60; n++) begin
			word = $random(seed);
			ra = 5'(1 + word[3:0] % 15);
			rb = word[8:4];
			rc = word[13:9];
			f3v = word[16:14];
			if (word[17]) begin
				r_op(f3v, word[18] && (f3v == 3'b000 || f3v == 3'b101), ra, rb, rc);
			end else if (f3v == 3'b001 || f3v == 3'b101) begin
				i_op(f3v, ra, rb, {1'b0, (f3v == 3'b101) && word[18], 5'b0, word[23:19]});
			end else begin
				i_op(f3v, ra, rb, word[29:18]);
			end
		end

		// upper immediates and jumps
		u_op(1'b0, 5'd20, 20'habcde);
		u_op(1'b1, 5'd21, 20'h12345);
		jump(1'b0, 5'd22, 5'd0, 21'h000ff0);
		jump(1'b0, 5'd22, 5'd0, 21'h1ff800);
		jump(1'b1, 5'd23, 5'd21, 21'h000001);
		jump(1'b1, 5'd23, 5'd23, 21'h0007f4);

		// equal operands and operands of opposite sign for the compares
		load_const(5'd12, 32'h0000_0010);
		load_const(5'd15, 32'hffff_fff0);
		i_op(3'b000, 5'd14, 5'd13, 12'h000);
		for (int k = 0; k < 6; k++) begin
			branch(br_kinds[k], 5'd1, 5'd2, 13'($random(seed)));
			branch(br_kinds[k], 5'd2, 5'd1, 13'($random(seed)));
			branch(br_kinds[k], 5'd13, 5'd14, 13'($random(seed)));
			branch(br_kinds[k], 5'd15, 5'd12, 13'($random(seed)));
		end

		// stores of each width, then loads that must not touch rd
		mem_op(1'b1, 3'b000, 5'd2, 5'd1, 12'h004);
		mem_op(1'b1, 3'b001, 5'd3, 5'd2, 12'hffe);
		mem_op(1'b1, 3'b010, 5'd4, 5'd3, 12'h800);
		mem_op(1'b0, 3'b010, 5'd9, 5'd1, 12'hff8);
		r_op(3'b000, 1'b0, 5'd10, 5'd9, 5'd1);
		mem_op(1'b0, 3'b000, 5'd11, 5'd5, 12'h123);
		mem_op(1'b0, 3'b100, 5'd11, 5'd6, 12'h7ff);

		// x0 as destination and source
		i_op(3'b000, 5'd0, 5'd1, 12'h123);
		r_op(3'b000, 1'b0, 5'd5, 5'd0, 5'd0);
		r_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
		u_op(1'b0, 5'd0, 20'hfffff);
		jump(1'b0, 5'd0, 5'd0, 21'h000008);
		bubble();
		i_op(3'b110, 5'd6, 5'd0, 12'h000);

		bubble();
		bubble();
		@(negedge i_clk);
		#1;
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: rv32i_core_slice.f
+incdir+include
logic/rv32i_pkg.sv
logic/rv32i_decode.sv
logic/rv32i_regfile.sv
logic/rv32i_issue.sv
logic/rv32i_execute.sv
logic/rv32i_core_slice.sv
verification/tb_rv32i_core_slice.sv

// File: Bender.yml
package:
  name: rv32i_core_slice

sources:
  - files:
      - logic/rv32i_pkg.sv
      - logic/rv32i_decode.sv
      - logic/rv32i_regfile.sv
      - logic/rv32i_issue.sv
      - logic/rv32i_execute.sv
      - logic/rv32i_core_slice.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_rv32i_core_slice.sv
